// File: sim/uartPatterns.txt
# op a b, hex: W addr data, R addr expected, S byte, F byte with stop 0
# T byte expected on txOut, L 1 or 0 for loopback
R 1 0000
W 0 000F
R 0 000F
W 1 0001
W 3 00FF
R 1 0001
W 2 00A5
W 2 003C
T A5
R 1 0001
R 2 00A5
S 3C
R 1 0021
R 3 003C
R 1 0001
F 81
R 3 0081
R 1 0041
W 1 0001
S 11
S 22
S 33
R 1 00A1
R 3 0011
R 1 00A1
R 3 0022
W 1 0001
R 3 0000
L 1
W 2 005A
T 5A
R 3 005A
L 0
W 1 0000
W 2 0077
R 1 0000

// File: build.f
common/uartPkg.sv
common/rxStreamIf.sv
uart/uartRegs.sv
uart/uartTx.sv
uart/uartRx.sv
source/uartTop.sv
sim/tbUart.sv

// File: runSim.sh
#!/bin/sh
# Compile the UART testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tbUart -f build.f &&
./obj_dir/VtbUart | tee /dev/stderr | grep "No errors" > /dev/null &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: sim/tbUart.sv
module tbUart;
  timeunit 1ns;
  timeprecision 1ps;

  logic              clk;
  logic              rst;
  logic              busEn;
  logic              busWr;
  uartPkg::busAddr_t busAddr;
  uartPkg::busWord_t busWrData;
  uartPkg::busWord_t busRdData;
  logic              rxIn;
  logic              txOut;
  logic              txInt;
  logic              rxInt;
  logic              serialLine;  // Frames from the pattern file
  logic              loopback;    // txOut back into rxIn

  int         bitClocks;   // Divisor plus one
  int         seed;
  int         testErrs;    // Errors in the current pattern line
  int         passCount;
  int         failCount;
  int         monErrs;     // Errors seen by the txOut decoder
  int         txIntCount;
  int         readIdx;     // Next decoded frame to check
  logic [7:0] txFrames[$];

  assign rxIn = loopback ? txOut : serialLine;

  uartTop uut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // txOut decoder, mid-bit samples on the falling clock edge
  //////////////////////////////////////////////////////////////////////

  initial begin : txMonitor
    logic [7:0] bits;
    forever begin
      @(negedge clk);
      if (rst === 1'b0 && txOut === 1'b0) begin
        repeat (bitClocks / 2) @(negedge clk);  // Middle of start bit
        if (txOut !== 1'b0) begin
          $display("ERR %0t txOut start bit expected 0 got %b", $time, txOut);
          monErrs++;
        end
        repeat (8) begin
          repeat (bitClocks) @(negedge clk);
          bits = {txOut, bits[7:1]};  // LSB first
        end
        repeat (bitClocks) @(negedge clk);
        if (txOut !== 1'b1) begin
          $display("ERR %0t txOut stop bit expected 1 got %b", $time, txOut);
          monErrs++;
        end
        txFrames.push_back(bits);
      end
    end
  end

  always @(negedge clk) begin
    if (txInt === 1'b1) txIntCount++;  // One count per high cycle
  end

  function automatic int frameTimeout();
    return bitClocks * uartPkg::frameBits * 4;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus and line operations, each returns on a rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic busWrite(input uartPkg::busAddr_t addr, input uartPkg::busWord_t data);
    busEn     <= 1'b1;
    busWr     <= 1'b1;
    busAddr   <= addr;
    busWrData <= data;
    @(posedge clk);  // Write lands here
    busEn <= 1'b0;
    busWr <= 1'b0;
    if (addr == uartPkg::regBrg) bitClocks = int'(data) + 1;
  endtask

  task automatic busRead(input uartPkg::busAddr_t addr, input uartPkg::busWord_t expected);
    busEn   <= 1'b1;
    busWr   <= 1'b0;
    busAddr <= addr;
    @(negedge clk);  // Read data settled mid-cycle
    if (busRdData !== expected) begin
      $display("ERR %0t busRdData expected %h got %h", $time, expected, busRdData);
      testErrs++;
    end
    @(posedge clk);
    busEn <= 1'b0;
    @(negedge clk);  // Idle bus cycle after the read
    // Popped receive register drops rxInt
    if (addr == uartPkg::regRxr && rxInt !== 1'b0) begin
      $display("ERR %0t rxInt expected 0 got %b", $time, rxInt);
      testErrs++;
    end
    @(posedge clk);
  endtask

  task automatic waitRxInt();
    int n;
    int limit;
    limit = frameTimeout();
    for (n = 0; n < limit; n++) begin
      @(negedge clk);
      if (rxInt === 1'b1) break;
    end
    @(posedge clk);
    if (n == limit) begin
      $display("Timeout, rxInt never rose after the received frame");
      testErrs++;
    end
  endtask

  // 8N1 frame on rxIn after a random idle gap
  task automatic driveFrame(input logic [7:0] data, input logic stopBit);
    logic [uartPkg::frameBits-1:0] frame;
    logic                          wasFull;
    int                            gap;
    frame = {stopBit, data, 1'b0};
    gap   = ($random(seed) & 15) + 1;
    @(negedge clk);
    wasFull = rxInt;  // Full register keeps rxInt up already
    repeat (gap) @(posedge clk);
    repeat (uartPkg::frameBits) begin
      serialLine <= frame[0];
      frame = frame >> 1;
      repeat (bitClocks) @(posedge clk);
    end
    serialLine <= 1'b1;
    repeat (bitClocks) @(posedge clk);  // One idle bit
    if (!wasFull) waitRxInt();
  endtask

  task automatic checkTxFrame(input logic [7:0] expected);
    int base;
    int n;
    int limit;
    base  = txIntCount;
    limit = frameTimeout();
    for (n = 0; n < limit; n++) begin
      @(posedge clk);
      if (txIntCount != base) break;
    end
    @(posedge clk);  // Catch a pulse longer than one cycle
    if (n == limit) begin
      $display("Timeout, no txInt pulse after the transmit write");
      testErrs++;
    end else if (txIntCount != base + 1) begin
      $display("ERR %0t txInt pulses expected 1 got %0d", $time, txIntCount - base);
      testErrs++;
    end
    if (txFrames.size() <= readIdx) begin
      $display("No frame was decoded on txOut");
      testErrs++;
    end else begin
      if (txFrames[readIdx] !== expected) begin
        $display("ERR %0t txOut byte expected %h got %h", $time, expected, txFrames[readIdx]);
        testErrs++;
      end
      readIdx++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Pattern file sequencer
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    int          fd;
    int          lineNo;
    int          got;
    string       text;
    logic [7:0]  op;
    logic [15:0] argA;
    logic [15:0] argB;
    seed       = 9;
    bitClocks  = 1;
    rst        <= 1'b1;
    busEn      <= 1'b0;
    busWr      <= 1'b0;
    busAddr    <= '0;
    busWrData  <= '0;
    serialLine <= 1'b1;  // Idle line
    loopback   <= 1'b0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    fd = $fopen("sim/uartPatterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file sim/uartPatterns.txt");
      failCount++;
    end
    lineNo = 0;
    while (fd != 0 && !$feof(fd)) begin
      lineNo++;
      got = $fgets(text, fd);
      if (got == 0 || text.len() < 3 || text[0] == "#") continue;  // Blank or comment
      argB     = '0;
      got      = $sscanf(text, "%c %h %h", op, argA, argB);
      testErrs = 0;
      case (op)
        "W": busWrite(argA[1:0], argB);
        "R": busRead(argA[1:0], argB);
        "S": driveFrame(argA[7:0], 1'b1);
        "F": driveFrame(argA[7:0], 1'b0);  // Stop bit low
        "T": checkTxFrame(argA[7:0]);
        "L": begin
          loopback <= argA[0];
          @(posedge clk);
        end
        default: begin
          $display("Unknown operation on pattern line %0d", lineNo);
          testErrs++;
        end
      endcase
      if (testErrs == 0) passCount++;
      else failCount++;
      $display("Test %0d %c %h %h %s", lineNo, op, argA, argB, (testErrs == 0) ? "pass" : "FAIL");
    end
    if (fd != 0) $fclose(fd);
    // Line idle and no frame beyond the expected ones
    @(negedge clk);
    if (txOut !== 1'b1) begin
      $display("ERR %0t txOut expected 1 got %b", $time, txOut);
      failCount++;
    end
    if (txFrames.size() != readIdx) begin
      $display("Unexpected extra frame seen on txOut");
      failCount++;
    end
    $display("Tests passed %0d, failed %0d, decoder errors %0d", passCount, failCount, monErrs);
    if (failCount == 0 && monErrs == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: source/uartTop.sv
module uartTop (
  input  logic              clk,
  input  logic              rst,
  input  logic              busEn,
  input  logic              busWr,
  input  uartPkg::busAddr_t busAddr,
  input  uartPkg::busWord_t busWrData,
  output uartPkg::busWord_t busRdData,
  input  logic              rxIn,
  output logic              txOut,
  output logic              txInt,
  output logic              rxInt
);

  uartPkg::busWord_t  divisor;    // Shared bit period
  logic               enable;
  logic               txValid;
  uartPkg::uartByte_t txData;
  logic               txReady;
  logic               txDone;
  logic               rxOverrun;

  rxStreamIf rxLink ();  // Receiver to register block

  uartRegs regs (
    .clk       (clk),
    .rst       (rst),
    .busEn     (busEn),
    .busWr     (busWr),
    .busAddr   (busAddr),
    .busWrData (busWrData),
    .busRdData (busRdData),
    .divisor   (divisor),
    .enable    (enable),
    .txValid   (txValid),
    .txData    (txData),
    .txReady   (txReady),
    .txDone    (txDone),
    .rx        (rxLink.sink),
    .rxOverrun (rxOverrun),
    .txInt     (txInt),
    .rxInt     (rxInt)
  );

  uartTx tx (
    .clk     (clk),
    .rst     (rst),
    .enable  (enable),
    .divisor (divisor),
    .txValid (txValid),
    .txData  (txData),
    .txReady (txReady),
    .txDone  (txDone),
    .txOut   (txOut)
  );

  uartRx rx (
    .clk       (clk),
    .rst       (rst),
    .enable    (enable),
    .divisor   (divisor),
    .rxIn      (rxIn),
    .rx        (rxLink.driver),
    .rxOverrun (rxOverrun)
  );

endmodule

// File: uart/uartRx.sv
module uartRx (
  input  logic              clk,
  input  logic              rst,
  input  logic              enable,
  input  uartPkg::busWord_t divisor,
  input  logic              rxIn,
  rxStreamIf.driver         rx,
  output logic              rxOverrun
);

  logic                            sync1;      // First synchronizer stage
  logic                            sync2;      // Synchronized line
  logic                            syncPrev;   // For edge detect
  logic                            active;     // Frame being sampled
  uartPkg::busWord_t               baudCnt;
  uartPkg::busWord_t               baudLimit;  // Half period before start sample
  logic [uartPkg::bitCntWidth-1:0] bitCnt;     // Samples taken
  uartPkg::uartByte_t              shiftReg;   // Data bits, LSB first
  logic                            stopOk;     // Stop bit level
  logic                            frameDone;  // Cycle after stop sample
  logic                            startEdge;
  logic                            sampleNow;
  logic                            lastBit;
  logic                            holdBlocked;  // Holding byte not taken

  //////////////////////////////////////////////////////////////////////
  // Synchronizer and edge detect
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      sync1    <= 1'b1;  // Idle line is high
      sync2    <= 1'b1;
      syncPrev <= 1'b1;
    end else begin
      sync1    <= rxIn;
      sync2    <= sync1;
      syncPrev <= sync2;
    end
  end

  assign startEdge   = syncPrev & ~sync2;
  assign baudLimit   = (bitCnt == '0) ? (divisor >> 1) : divisor;  // Mid-bit
  assign sampleNow   = active & (baudCnt == baudLimit);
  assign lastBit     = (bitCnt == uartPkg::bitCntWidth'(uartPkg::frameBits - 1));
  assign holdBlocked = rx.valid & ~rx.ready;

  //////////////////////////////////////////////////////////////////////
  // Sampling FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || !enable) begin
      active    <= 1'b0;
      baudCnt   <= '0;
      bitCnt    <= '0;
      frameDone <= 1'b0;
    end else begin
      frameDone <= 1'b0;
      if (!active) begin
        if (startEdge) begin
          active  <= 1'b1;
          baudCnt <= '0;
          bitCnt  <= '0;
        end
      end else if (sampleNow) begin
        baudCnt <= '0;
        bitCnt  <= bitCnt + 1'b1;
        if (bitCnt == '0 && sync2) begin
          active <= 1'b0;  // Glitch, not a start bit
        end else if (lastBit) begin
          active    <= 1'b0;
          frameDone <= 1'b1;
        end
      end else begin
        baudCnt <= baudCnt + 1'b1;
      end
    end
  end

  // Payload capture
  always_ff @(posedge clk) begin
    if (sampleNow) begin
      if (lastBit) stopOk <= sync2;
      else if (bitCnt != '0) shiftReg <= {sync2, shiftReg[uartPkg::byteWidth-1:1]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Holding register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || !enable) begin
      rx.valid  <= 1'b0;
      rxOverrun <= 1'b0;
    end else begin
      rxOverrun <= 1'b0;
      if (frameDone && holdBlocked) rxOverrun <= 1'b1;  // New frame dropped
      else if (frameDone) rx.valid <= 1'b1;
      else if (rx.ready) rx.valid <= 1'b0;              // Taken by register block
    end
  end

  always_ff @(posedge clk) begin
    if (frameDone && !holdBlocked) begin
      rx.data     <= shiftReg;
      rx.frameErr <= ~stopOk;
    end
  end

  // Offered byte must not change before it is taken
  assert property (@(posedge clk) disable iff (rst)
    (rx.valid && !rx.ready) |=> $stable(rx.data));

endmodule

// File: uart/uartTx.sv
module uartTx (
  input  logic               clk,
  input  logic               rst,
  input  logic               enable,
  input  uartPkg::busWord_t  divisor,
  input  logic               txValid,
  input  uartPkg::uartByte_t txData,
  output logic               txReady,
  output logic               txDone,
  output logic               txOut
);

  logic                             busy;       // Frame in flight
  logic                             stopEnd;    // Last cycle of stop bit passed
  uartPkg::busWord_t                baudCnt;    // Clocks within current bit
  logic [uartPkg::bitCntWidth-1:0]  bitCnt;     // Bits completed
  logic [uartPkg::frameBits-1:0]    shiftReg;   // Frame, LSB goes out first
  logic                             baudMatch;  // End of bit period
  logic                             lastBit;
  logic                             loadFrame;

  assign txReady   = enable & ~busy;
  assign loadFrame = txValid & txReady;
  assign baudMatch = busy & ~stopEnd & (baudCnt == divisor);
  assign lastBit   = (bitCnt == uartPkg::bitCntWidth'(uartPkg::frameBits - 1));

  //////////////////////////////////////////////////////////////////////
  // Control FSM and counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || !enable) begin  // Disable aborts any frame
      busy    <= 1'b0;
      stopEnd <= 1'b0;
      baudCnt <= '0;
      bitCnt  <= '0;
      txDone  <= 1'b0;
      txOut   <= 1'b1;  // Idle line
    end else begin
      txDone <= stopEnd;                       // Pulse after stop bit ends
      txOut  <= busy ? shiftReg[0] : 1'b1;     // One clock behind the shifter
      if (loadFrame) begin
        busy    <= 1'b1;
        baudCnt <= '0;
        bitCnt  <= '0;
      end else if (stopEnd) begin
        // Stop bit has fully left txOut
        busy    <= 1'b0;
        stopEnd <= 1'b0;
      end else if (baudMatch) begin
        baudCnt <= '0;
        bitCnt  <= bitCnt + 1'b1;
        if (lastBit) stopEnd <= 1'b1;
      end else if (busy) begin
        baudCnt <= baudCnt + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Shift register
  //////////////////////////////////////////////////////////////////////

  // Stop bit in MSB, start bit in LSB
  always_ff @(posedge clk) begin
    if (loadFrame) shiftReg <= {1'b1, txData, 1'b0};
    else if (baudMatch) shiftReg <= {1'b1, shiftReg[uartPkg::frameBits-1:1]};  // Fill with idle
  end

  // Line never drops outside a frame
  assert property (@(posedge clk) disable iff (rst) !busy |-> txOut);

endmodule

// File: uart/uartRegs.sv
module uartRegs (
  input  logic               clk,
  input  logic               rst,
  input  logic               busEn,
  input  logic               busWr,
  input  uartPkg::busAddr_t  busAddr,
  input  uartPkg::busWord_t  busWrData,
  output uartPkg::busWord_t  busRdData,
  output uartPkg::busWord_t  divisor,
  output logic               enable,
  output logic               txValid,
  output uartPkg::uartByte_t txData,
  input  logic               txReady,
  input  logic               txDone,
  rxStreamIf.sink            rx,
  input  logic               rxOverrun,
  output logic               txInt,
  output logic               rxInt
);

  //////////////////////////////////////////////////////////////////////
  // Bus decode
  //////////////////////////////////////////////////////////////////////

  logic               regWr;         // Bus write cycle
  logic               regRd;         // Bus read cycle
  logic               brgWr;
  logic               ctlWr;
  logic               txrWr;
  logic               rxrRd;         // Read of receive register
  logic               rxAccept;      // Byte handshake from receiver
  uartPkg::uartByte_t txByte;        // Last byte sent
  uartPkg::uartByte_t rxByte;        // Receive register
  logic               rxFull;
  logic               frameErrFlag;
  logic               overrunFlag;
  uartPkg::busWord_t  ctlView;       // Software view of control
  uartPkg::busWord_t  txrView;
  uartPkg::busWord_t  rxrView;

  assign regWr = busEn & busWr;
  assign regRd = busEn & ~busWr;
  assign brgWr = regWr && (busAddr == uartPkg::regBrg);
  assign ctlWr = regWr && (busAddr == uartPkg::regCtl);
  assign txrWr = regWr && (busAddr == uartPkg::regTxr);
  assign rxrRd = regRd && (busAddr == uartPkg::regRxr);

  //////////////////////////////////////////////////////////////////////
  // Divisor and enable
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      divisor <= '0;
      enable  <= 1'b0;
    end else begin
      if (brgWr) divisor <= busWrData;
      if (ctlWr) enable <= busWrData[uartPkg::ctlEnable];  // Status bits ignored on write
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Transmit request
  //////////////////////////////////////////////////////////////////////

  // Write while busy or disabled is dropped
  assign txValid = txrWr & txReady;
  assign txData  = busWrData[uartPkg::byteWidth-1:0];
  assign txInt   = txDone;  // One-cycle pulse straight from transmitter

  // Readback copy of the byte in flight
  always_ff @(posedge clk) begin
    if (txValid) txByte <= txData;
  end

  //////////////////////////////////////////////////////////////////////
  // Receive register and status
  //////////////////////////////////////////////////////////////////////

  assign rx.ready = ~rxFull;
  assign rxAccept = rx.valid & rx.ready;
  assign rxInt    = rxFull;  // Level until software reads

  always_ff @(posedge clk) begin
    if (rst) begin
      rxFull       <= 1'b0;
      frameErrFlag <= 1'b0;
      overrunFlag  <= 1'b0;
    end else begin
      if (rxAccept) rxFull <= 1'b1;
      else if (rxrRd && rxFull) rxFull <= 1'b0;  // Read pops the byte
      // Control write clears sticky flags
      // A new event in the same cycle wins
      if (ctlWr) begin
        frameErrFlag <= 1'b0;
        overrunFlag  <= 1'b0;
      end
      if (rxAccept && rx.frameErr) frameErrFlag <= 1'b1;
      if (rxOverrun) overrunFlag <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rxAccept) rxByte <= rx.data;
  end

  //////////////////////////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ctlView = '0;
    ctlView[uartPkg::ctlEnable]   = enable;
    ctlView[uartPkg::ctlTxBusy]   = enable & ~txReady;  // Idle while disabled
    ctlView[uartPkg::ctlRxFull]   = rxFull;
    ctlView[uartPkg::ctlFrameErr] = frameErrFlag;
    ctlView[uartPkg::ctlOverrun]  = overrunFlag;
  end

  assign txrView = {{(uartPkg::busWidth - uartPkg::byteWidth){1'b0}}, txByte};
  // Empty register reads as zero
  assign rxrView = rxFull ? {{(uartPkg::busWidth - uartPkg::byteWidth){1'b0}}, rxByte} : '0;

  always_comb begin
    busRdData = '0;  // Bus idle or write
    if (regRd) begin
      case (busAddr)
        uartPkg::regBrg: busRdData = divisor;
        uartPkg::regCtl: busRdData = ctlView;
        uartPkg::regTxr: busRdData = txrView;
        uartPkg::regRxr: busRdData = rxrView;
        default:         busRdData = '0;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Transmitter turns busy the cycle after a request
  assert property (@(posedge clk) disable iff (rst)
    txValid |=> !txReady);

  // Empty read with no byte arriving leaves the register empty
  assert property (@(posedge clk) disable iff (rst)
    (rxrRd && !rxFull && !rx.valid) |=> !rxFull);

endmodule

// File: common/rxStreamIf.sv
// Received byte path from receiver to register block
// Byte moves on an edge with valid and ready both high
interface rxStreamIf;

  logic               valid;     // Holding register occupied
  logic               ready;     // Receive register empty
  uartPkg::uartByte_t data;      // Received byte
  logic               frameErr;  // Stop bit was low

  modport driver (
    output valid,
    output data,
    output frameErr,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    input  frameErr,
    output ready
  );

endinterface

// File: common/uartPkg.sv
package uartPkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int busWidth  = 16;  // Processor bus data width
  localparam int byteWidth = 8;   // Serial payload width
  localparam int addrWidth = 2;   // Four registers

  typedef logic [busWidth-1:0]  busWord_t;
  typedef logic [byteWidth-1:0] uartByte_t;
  typedef logic [addrWidth-1:0] busAddr_t;

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////

  localparam busAddr_t regBrg = 2'd0;  // Baud divisor
  localparam busAddr_t regCtl = 2'd1;  // Control and status
  localparam busAddr_t regTxr = 2'd2;  // Transmit byte
  localparam busAddr_t regRxr = 2'd3;  // Receive byte

  // Control register bit positions
  localparam int ctlEnable   = 0;  // Only writable bit
  localparam int ctlTxBusy   = 4;  // Frame in flight
  localparam int ctlRxFull   = 5;  // Byte waiting
  localparam int ctlFrameErr = 6;  // Sticky
  localparam int ctlOverrun  = 7;  // Sticky

  //////////////////////////////////////////////////////////////////////
  // Frame format
  //////////////////////////////////////////////////////////////////////

  // 8N1 frame
  // start + 8 data + stop
  localparam int frameBits   = 10;
  localparam int bitCntWidth = $clog2(frameBits);  // Bit index counter

endpackage
